//--- rtl/sram_array.sv
// bank of sram macros under test
`timescale 1ns/1ps

module sram_array
   import sram_test_pkg::*;
(
   input  logic        clk,
   input  port0_req_t  p0_i,
   input  port1_req_t  p1_i,
   output macro_dout_t dout_o
);

   generate
      for (genvar g = 0; g < NUM_MACROS; g++) begin : g_macro
         // shape from the package table
         localparam int AW = MACRO_ADDR_W[g];
         localparam int DW = MACRO_DATA_W[g];

         logic [DW-1:0] dout0;
         logic [DW-1:0] dout1;

         // address and data sliced to this macro's width
         sram_macro #(
            .ADDR_W    (AW),
            .DATA_W    (DW),
            .HAS_PORT1 (MACRO_DUAL[g])
         ) u_macro (
            .clk      (clk),
            .cs0_i    (p0_i.cs[g]),
            .we0_i    (p0_i.we),
            .wmask0_i (p0_i.wmask),
            .addr0_i  (p0_i.addr[AW-1:0]),
            .din0_i   (p0_i.din[DW-1:0]),
            .dout0_o  (dout0),
            .cs1_i    (p1_i.cs[g]),
            .addr1_i  (p1_i.addr[AW-1:0]),
            .dout1_o  (dout1)
         );

         // narrow macros read back with upper lanes zero
         assign dout_o[g].dout0 = DATA_W'(dout0);
         // missing port 1 already reads zero from the macro
         assign dout_o[g].dout1 = DATA_W'(dout1);
      end
   endgenerate

endmodule

//--- rtl/sram_capture.sv
// macro output holding registers
`timescale 1ns/1ps

module sram_capture
   import sram_test_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   input  macro_dout_t            dout_i,
   input  logic [MACRO_SEL_W-1:0] sel_macro_i,
   input  logic                   sel_port_i,
   output word_t                  word_o
);

   // one word per macro per port
   macro_dout_t hold_q;

   // every output sampled each cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_q <= '0;
      end else begin
         hold_q <= dout_i;
      end
   end

   // word named by the controller, port 1 when sel_port_i is set
   always_comb begin
      if (sel_port_i) begin
         word_o = hold_q[sel_macro_i].dout1;
      end else begin
         word_o = hold_q[sel_macro_i].dout0;
      end
   end

endmodule

//--- rtl/sram_macro.sv
// behavioral sram macro
`timescale 1ns/1ps

module sram_macro
   import sram_test_pkg::*;
#(
   parameter int ADDR_W    = 9,
   parameter int DATA_W    = 32,
   parameter bit HAS_PORT1 = 1'b1
) (
   input  logic              clk,
   // read-write port
   input  logic              cs0_i,
   input  logic              we0_i,
   input  logic [SEL_W-1:0]  wmask0_i,
   input  logic [ADDR_W-1:0] addr0_i,
   input  logic [DATA_W-1:0] din0_i,
   output logic [DATA_W-1:0] dout0_o,
   // read-only port
   input  logic              cs1_i,
   input  logic [ADDR_W-1:0] addr1_i,
   output logic [DATA_W-1:0] dout1_o
);

   // byte lanes this macro has, the 8-bit one only has lane 0
   localparam int NUM_BYTES = DATA_W / 8;

   logic [DATA_W-1:0] mem [2**ADDR_W];

   // port 0, masked write or registered read
   always_ff @(posedge clk) begin
      if (cs0_i) begin
         if (we0_i) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   // port 1 only on dual-port shapes
   generate
      if (HAS_PORT1) begin : g_port1
         // output holds between reads
         always_ff @(posedge clk) begin
            if (cs1_i) begin
               dout1_o <= mem[addr1_i];
            end
         end
      end else begin : g_no_port1
         assign dout1_o = '0;
      end
   endgenerate

endmodule

//--- rtl/sram_test_pkg.sv
// sram test wrapper definitions
package sram_test_pkg;

   // bus geometry
   localparam int DATA_W      = 32;
   localparam int SEL_W       = DATA_W / 8;
   localparam int ADR_W       = 32;
   localparam int WORD_ADDR_W = 10;

   // macro table, index is the macro number
   localparam int NUM_MACROS   = 4;
   localparam int MACRO_SEL_W  = $clog2(NUM_MACROS);
   localparam int MACRO_ADDR_W [NUM_MACROS] = '{10, 8, 9, 9};
   localparam int MACRO_DATA_W [NUM_MACROS] = '{8, 32, 32, 32};
   // second read-only port present
   localparam bit MACRO_DUAL   [NUM_MACROS] = '{1'b1, 1'b1, 1'b1, 1'b0};

   // address map, byte offset in bits 1..0 is ignored
   localparam int ADR_WORD_LSB  = 2;
   localparam int ADR_PORT_BIT  = ADR_WORD_LSB + WORD_ADDR_W;
   localparam int ADR_MACRO_LSB = ADR_PORT_BIT + 1;

   typedef logic [DATA_W-1:0] word_t;

   // wishbone classic request from the master
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [SEL_W-1:0] sel;
      logic [ADR_W-1:0] adr;
      word_t            dat;
   } wb_req_t;

   // wishbone classic response
   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   // read-write port, shared by all macros, chip selects active high
   typedef struct packed {
      logic [NUM_MACROS-1:0]  cs;
      logic                   we;
      logic [SEL_W-1:0]       wmask;
      logic [WORD_ADDR_W-1:0] addr;
      word_t                  din;
   } port0_req_t;

   // read-only port
   typedef struct packed {
      logic [NUM_MACROS-1:0]  cs;
      logic [WORD_ADDR_W-1:0] addr;
   } port1_req_t;

   // outputs of one macro, zero-extended to bus width
   typedef struct packed {
      word_t dout1;
      word_t dout0;
   } macro_port_t;

   typedef macro_port_t [NUM_MACROS-1:0] macro_dout_t;

endpackage

//--- rtl/sram_test_top.sv
// sram test wrapper top level
`timescale 1ns/1ps

module sram_test_top
   import sram_test_pkg::*;
(
   input  logic    clk,
   input  logic    rstn,
   input  wb_req_t wb_i,
   output wb_rsp_t wb_o
);

   // controller to macro ports
   port0_req_t p0;
   port1_req_t p1;

   // raw macro outputs
   macro_dout_t dout;

   // word selection and the captured word going back
   logic [MACRO_SEL_W-1:0] rd_macro;
   logic                   rd_port;
   word_t                  rd_word;

   // bus slave and access sequencer
   wb_sram_ctrl u_ctrl (
      .clk        (clk),
      .rstn       (rstn),
      .wb_i       (wb_i),
      .wb_o       (wb_o),
      .p0_o       (p0),
      .p1_o       (p1),
      .rd_macro_o (rd_macro),
      .rd_port_o  (rd_port),
      .rd_word_i  (rd_word)
   );

   // the four macros under test
   sram_array u_array (
      .clk    (clk),
      .p0_i   (p0),
      .p1_i   (p1),
      .dout_o (dout)
   );

   // holding stage between macros and bus
   sram_capture u_capture (
      .clk         (clk),
      .rstn        (rstn),
      .dout_i      (dout),
      .sel_macro_i (rd_macro),
      .sel_port_i  (rd_port),
      .word_o      (rd_word)
   );

endmodule

//--- rtl/wb_sram_ctrl.sv
// wishbone slave for sram access
`timescale 1ns/1ps

module wb_sram_ctrl
   import sram_test_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   input  wb_req_t                wb_i,
   output wb_rsp_t                wb_o,
   output port0_req_t             p0_o,
   output port1_req_t             p1_o,
   output logic [MACRO_SEL_W-1:0] rd_macro_o,
   output logic                   rd_port_o,
   input  word_t                  rd_word_i
);

   // idle, macro access, capture, ack, ack drop
   typedef enum logic [2:0] {
      S_IDLE,
      S_ACCESS,
      S_CAPTURE,
      S_RESP,
      S_DONE
   } state_t;

   state_t state_q;

   // decoded address fields
   logic [WORD_ADDR_W-1:0] word_idx;
   logic                   port_sel;
   logic [MACRO_SEL_W-1:0] macro_idx;
   logic                   req_valid;

   // chip select decode and registers
   logic [NUM_MACROS-1:0] cs0_d;
   logic [NUM_MACROS-1:0] cs1_d;
   logic [NUM_MACROS-1:0] cs0_q;
   logic [NUM_MACROS-1:0] cs1_q;

   // access control
   logic                   we_q;
   logic [MACRO_SEL_W-1:0] rd_macro_q;
   logic                   rd_port_q;

   // payload held for the macro ports
   logic [SEL_W-1:0]       wmask_q;
   logic [WORD_ADDR_W-1:0] addr_q;
   word_t                  din_q;

   // bus response
   logic  ack_q;
   word_t dat_q;

   // keep only the word bits the addressed macro has, upper words alias
   function automatic logic [WORD_ADDR_W-1:0] trunc_addr(
      input logic [MACRO_SEL_W-1:0] m,
      input logic [WORD_ADDR_W-1:0] w
   );
      logic [WORD_ADDR_W-1:0] mask;
      mask = '0;
      for (int i = 0; i < NUM_MACROS; i++) begin
         if (int'(m) == i) begin
            mask = WORD_ADDR_W'((1 << MACRO_ADDR_W[i]) - 1);
         end
      end
      return w & mask;
   endfunction

   assign word_idx  = wb_i.adr[ADR_WORD_LSB +: WORD_ADDR_W];
   assign port_sel  = wb_i.adr[ADR_PORT_BIT];
   assign macro_idx = wb_i.adr[ADR_MACRO_LSB +: MACRO_SEL_W];

   // new transfer only from idle
   assign req_valid = (state_q == S_IDLE) && wb_i.cyc && wb_i.stb;

   // one-hot select, writes always go through port 0
   // port 1 read on a single-port macro selects nothing
   always_comb begin
      cs0_d = '0;
      cs1_d = '0;
      if (wb_i.we || !port_sel) begin
         cs0_d[macro_idx] = 1'b1;
      end else begin
         for (int i = 0; i < NUM_MACROS; i++) begin
            if (int'(macro_idx) == i && MACRO_DUAL[i]) begin
               cs1_d[i] = 1'b1;
            end
         end
      end
   end

   // sequencer, ack three edges after the request is sampled
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q    <= S_IDLE;
         cs0_q      <= '0;
         cs1_q      <= '0;
         we_q       <= 1'b0;
         rd_macro_q <= '0;
         rd_port_q  <= 1'b0;
         ack_q      <= 1'b0;
         dat_q      <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (req_valid) begin
                  cs0_q      <= cs0_d;
                  cs1_q      <= cs1_d;
                  we_q       <= wb_i.we;
                  rd_macro_q <= macro_idx;
                  rd_port_q  <= port_sel;
                  state_q    <= S_ACCESS;
               end
            end
            S_ACCESS: begin
               // macro has taken the access, release selects
               cs0_q   <= '0;
               cs1_q   <= '0;
               state_q <= S_CAPTURE;
            end
            S_CAPTURE: begin
               state_q <= S_RESP;
            end
            S_RESP: begin
               ack_q   <= 1'b1;
               dat_q   <= we_q ? '0 : rd_word_i;
               state_q <= S_DONE;
            end
            default: begin
               // single-cycle ack, master drops stb now
               ack_q   <= 1'b0;
               dat_q   <= '0;
               state_q <= S_IDLE;
            end
         endcase
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      if (req_valid) begin
         wmask_q <= wb_i.sel;
         addr_q  <= trunc_addr(macro_idx, word_idx);
         din_q   <= wb_i.dat;
      end
   end

   assign p0_o.cs    = cs0_q;
   assign p0_o.we    = we_q;
   assign p0_o.wmask = wmask_q;
   assign p0_o.addr  = addr_q;
   assign p0_o.din   = din_q;

   // read-only port shares the word address
   assign p1_o.cs   = cs1_q;
   assign p1_o.addr = addr_q;

   assign rd_macro_o = rd_macro_q;
   assign rd_port_o  = rd_port_q;

   assign wb_o.ack = ack_q;
   assign wb_o.dat = dat_q;

endmodule

//--- sources.f
+incdir+tb
rtl/sram_test_pkg.sv
rtl/sram_macro.sv
rtl/sram_array.sv
rtl/sram_capture.sv
rtl/wb_sram_ctrl.sv
rtl/sram_test_top.sv
tb/tb_sram_test.sv

//--- tb/tb_sram_checks.svh
// sram test reference model and checks
`ifndef TB_SRAM_CHECKS_SVH
`define TB_SRAM_CHECKS_SVH

// macro shapes by macro number
localparam int DEPTH_BITS [4] = '{10, 8, 9, 9};
localparam int LANES      [4] = '{1, 4, 4, 4};
localparam bit HAS_RO     [4] = '{1'b1, 1'b1, 1'b1, 1'b0};
// edges from request sampling to ack
localparam int ACK_LATENCY = 3;
localparam int ACK_TIMEOUT = 20;

// reference contents per macro location
word_t mdl [4][1024];

task automatic fail_stop(input string why);
   $display("%s", why);
   $display("TEST RESULT: FAIL");
   $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                          $time, name, got, exp));
   end
endtask

task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
   if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                          $time, name, got, exp));
   end
endtask

task automatic check_count(input string name, input int got, input int exp);
   if (got != exp) begin
      fail_stop($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                          $time, name, got, exp));
   end
endtask

// upper word bits alias onto lower words
function automatic int model_index(input int m, input int w);
   return w & ((1 << DEPTH_BITS[m]) - 1);
endfunction

// only the lanes the macro has take data
function automatic void model_write(input int m, input int w, input logic [3:0] sel,
                                    input word_t d);
   int i;
   i = model_index(m, w);
   for (int b = 0; b < LANES[m]; b++) begin
      if (sel[b]) begin
         mdl[m][i][b*8 +: 8] = d[b*8 +: 8];
      end
   end
endfunction

// missing lanes and missing ports read as zero
function automatic word_t model_read(input int m, input int w, input logic port);
   word_t r;
   r = '0;
   if (!port || HAS_RO[m]) begin
      for (int b = 0; b < LANES[m]; b++) begin
         r[b*8 +: 8] = mdl[m][model_index(m, w)][b*8 +: 8];
      end
   end
   return r;
endfunction

`endif

//--- tb/tb_sram_test.sv
// sram test wrapper testbench
`timescale 1ns/1ps

module tb_sram_test
   import sram_test_pkg::*;
();

   localparam int DRIVE_DLY  = 2;
   localparam int NUM_WRITES = 300;

   logic    clk;
   logic    rstn;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   // locations written so far for random reads
   int wr_macro [$];
   int wr_word  [$];
   bit seen [4][1024];

   `include "tb_sram_checks.svh"

   sram_test_top dut0 (
      .clk  (clk),
      .rstn (rstn),
      .wb_i (wb_req),
      .wb_o (wb_rsp)
   );

   always #20 clk = ~clk;

   // one classic transfer with ack latency and pulse width checks
   task automatic bus_transfer(input logic we, input int m, input int w, input logic port,
                               input logic [3:0] sel, input word_t d, output word_t rdata);
      logic [31:0] adr;
      int          n;
      // random byte offset and high bits are ignored by the slave
      adr        = $urandom();
      adr[14:13] = 2'(m);
      adr[12]    = port;
      adr[11:2]  = 10'(w);
      @(posedge clk);
      #DRIVE_DLY;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.sel = sel;
      wb_req.adr = adr;
      wb_req.dat = d;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > ACK_TIMEOUT) begin
            fail_stop("the DUT gave no acknowledge within the timeout");
         end
      end while (!wb_rsp.ack);
      // first edge sampling stb counts as zero
      check_count("ack latency", n - 1, ACK_LATENCY);
      rdata = wb_rsp.dat;
      if (we) begin
         check_word("wb_o.dat on write", wb_rsp.dat, '0);
      end
      #1;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      @(posedge clk);
      #1;
      // ack gone after a single cycle
      check_rsp("wb_o after ack", wb_rsp, '0);
   endtask

   task automatic wb_write(input int m, input int w, input logic [3:0] sel, input word_t d);
      word_t unused;
      bus_transfer(1'b1, m, w, 1'b0, sel, d, unused);
   endtask

   task automatic wb_read(input int m, input int w, input logic port, output word_t rdata);
      bus_transfer(1'b0, m, w, port, 4'hf, $urandom(), rdata);
   endtask

   initial begin
      int         m;
      int         w;
      int         pick;
      logic [3:0] sel;
      word_t      d;
      word_t      rd;
      void'($urandom(32'hfc1c_1592));
      clk    = 1'b0;
      rstn   = 1'b0;
      wb_req = '0;
      repeat (5) @(posedge clk);
      #DRIVE_DLY;
      rstn = 1'b1;
      @(posedge clk);
      #1;
      check_rsp("wb_o after reset", wb_rsp, '0);

      // random writes each followed by a read of an earlier location
      for (int i = 0; i < NUM_WRITES; i++) begin
         m   = $urandom_range(3, 0);
         // small word set per macro so locations get rewritten
         w   = $urandom_range(31, 0) + 256 * $urandom_range(3, 0);
         sel = $urandom();
         d   = $urandom();
         // a fresh location gets every lane so no lane stays undefined
         if (!seen[m][model_index(m, w)]) begin
            sel = 4'hf;
         end
         seen[m][model_index(m, w)] = 1'b1;
         wb_write(m, w, sel, d);
         model_write(m, w, sel, d);
         wr_macro.push_back(m);
         wr_word.push_back(w);
         pick = $urandom_range(wr_macro.size() - 1, 0);
         m    = wr_macro[pick];
         // sometimes hit an alias above the macro depth
         w    = (wr_word[pick] + $urandom_range(1, 0) * (1 << DEPTH_BITS[m])) % 1024;
         wb_read(m, w, 1'b0, rd);
         check_word("wb_o.dat port 0 read", rd, model_read(m, w, 1'b0));
      end

      // read-only port against the model where macro 3 has none
      for (int i = 0; i < 40; i++) begin
         pick = $urandom_range(wr_macro.size() - 1, 0);
         m    = wr_macro[pick];
         w    = wr_word[pick];
         wb_read(m, w, 1'b1, rd);
         check_word("wb_o.dat port 1 read", rd, model_read(m, w, 1'b1));
      end
      for (int i = 0; i < 4; i++) begin
         d = $urandom();
         wb_write(i, 7, 4'hf, d);
         model_write(i, 7, 4'hf, d);
         wb_read(i, 7, 1'b1, rd);
         check_word("wb_o.dat port 1 per macro", rd, model_read(i, 7, 1'b1));
      end

      // byte macro honors the lane 0 mask and never returns upper lanes
      w = $urandom_range(1023, 0);
      d = $urandom();
      wb_write(0, w, 4'hf, d);
      wb_write(0, w, 4'he, ~d);
      wb_read(0, w, 1'b0, rd);
      check_word("wb_o.dat macro 0 masked byte", rd, {24'h0, d[7:0]});

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
